// ==== logic/icache_pkg.sv ====
package icache_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////
    localparam int index_width  = 4;
    localparam int offset_width = 2;
    localparam int tag_width    = 32 - index_width - offset_width;
    localparam int num_sets     = 16;
    localparam int num_ways     = 2;

    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;  // bit 0 also names the way for index ops
    } icache_addr_t;

    typedef struct packed {
        logic flush;
        logic stall;
    } pipe_ctrl_t;

    typedef enum logic [1:0] {
        cacop_init        = 2'd0,
        cacop_index_inval = 2'd1,
        cacop_hit_inval   = 2'd2
    } cacop_kind_e;

    //////////////////////////////
    // op word, two decodes
    //////////////////////////////
    typedef struct packed {
        logic        barrier;  // ibar marker
        logic [30:0] rsvd;
    } ibar_view_t;

    typedef struct packed {
        logic [26:0] rsvd_hi;
        cacop_kind_e kind;
        logic [2:0]  rsvd_lo;
    } cacop_view_t;

    typedef union packed {
        ibar_view_t  ibar;
        cacop_view_t cacop;
    } cacop_word_u;

    typedef struct packed {
        logic         valid;
        logic         opflag;    // cache operation, not a fetch
        logic         uncached;
        icache_addr_t addr;
        cacop_word_u  op;
    } fetch_req_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_wait,
        operation,
        flush
    } fsm_state_e;

endpackage

// ==== logic/icache_req_buf.sv ====
`timescale 1ns/10ps

module icache_req_buf (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   we,
    input  icache_pkg::fetch_req_t req_in,
    output icache_pkg::fetch_req_t req_out
);

    logic                     valid_q;
    logic                     opflag_q;
    logic                     uncached_q;
    icache_pkg::icache_addr_t addr_q;
    icache_pkg::cacop_word_u  op_q;

    // control bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q  <= 1'b0;
            opflag_q <= 1'b0;
        end else if (we) begin
            valid_q  <= req_in.valid;
            opflag_q <= req_in.opflag;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (we) begin
            uncached_q <= req_in.uncached;
            addr_q     <= req_in.addr;
            op_q       <= req_in.op;
        end
    end

    assign req_out = '{valid: valid_q, opflag: opflag_q, uncached: uncached_q,
                       addr: addr_q, op: op_q};

    // an op never carries the uncached attribute
    a_no_uncached_op: assert property (@(posedge clk) disable iff (!rstn)
        we |-> !(req_in.opflag && req_in.uncached));

endmodule

// ==== logic/icache_tagv_array.sv ====
`timescale 1ns/10ps

module icache_tagv_array (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic [icache_pkg::index_width-1:0]   rd_index,
    input  icache_pkg::icache_addr_t             cmp_addr,
    input  logic [icache_pkg::num_ways-1:0]      we,
    input  icache_pkg::icache_addr_t             wr_addr,
    input  logic [icache_pkg::num_ways-1:0]      inval,
    input  logic                                 init_set,
    output logic [icache_pkg::num_ways-1:0]      hit
);

    logic [icache_pkg::tag_width-1:0] tag_mem [icache_pkg::num_ways][icache_pkg::num_sets];
    logic [icache_pkg::tag_width-1:0] tag_q [icache_pkg::num_ways];
    logic [icache_pkg::num_sets-1:0]  valid [icache_pkg::num_ways];
    logic [icache_pkg::num_sets-1:0]  valid_nxt [icache_pkg::num_ways];
    logic [icache_pkg::num_ways-1:0]  valid_q;
    logic [icache_pkg::num_ways-1:0]  clr;

    always_comb begin
        clr = inval;
        if (init_set) begin
            clr[wr_addr.offset[0]] = 1'b1;  // way picked by addr bit 0
        end
    end

    // valid bits after this cycle's refill / invalidate
    always_comb begin
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            valid_nxt[w] = valid[w];
            if (we[w]) valid_nxt[w][wr_addr.index] = 1'b1;
            if (clr[w]) valid_nxt[w][wr_addr.index] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < icache_pkg::num_ways; w++) begin
                valid[w] <= '0;
            end
            valid_q <= '0;
        end else begin
            for (int w = 0; w < icache_pkg::num_ways; w++) begin
                valid[w]   <= valid_nxt[w];
                valid_q[w] <= valid_nxt[w][rd_index];  // write-first
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            if (we[w]) tag_mem[w][wr_addr.index] <= wr_addr.tag;
            if (we[w] && wr_addr.index == rd_index) begin
                tag_q[w] <= wr_addr.tag;  // bypass the refill
            end else begin
                tag_q[w] <= tag_mem[w][rd_index];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == cmp_addr.tag);
        end
    end

    // refill only on a miss, so a tag lives in one way at most
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(hit));

endmodule

// ==== logic/icache_data_array.sv ====
`timescale 1ns/10ps

module icache_data_array (
    input  logic                               clk,
    input  logic [icache_pkg::index_width-1:0] rd_index,
    input  logic [icache_pkg::num_ways-1:0]    we,
    input  logic [icache_pkg::index_width-1:0] wr_index,
    input  logic [31:0]                        wdata,
    output logic [31:0]                        rdata0,
    output logic [31:0]                        rdata1
);

    logic [31:0] mem [icache_pkg::num_ways][icache_pkg::num_sets];
    logic [31:0] rd_q [icache_pkg::num_ways];

    //////////////////////////////
    // one word per set and way
    //////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::num_ways; w++) begin
            if (we[w]) begin
                mem[w][wr_index] <= wdata;
            end
            if (we[w] && wr_index == rd_index) begin
                rd_q[w] <= wdata;  // refill seen by the next lookup
            end else begin
                rd_q[w] <= mem[w][rd_index];
            end
        end
    end

    assign rdata0 = rd_q[0];
    assign rdata1 = rd_q[1];

endmodule

// ==== logic/icache_lru.sv ====
`timescale 1ns/10ps

module icache_lru (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic [icache_pkg::index_width-1:0] index,
    input  logic                               use0,
    input  logic                               use1,
    output logic                               victim
);

    logic [icache_pkg::num_sets-1:0] lru_q;  // 1 means way 1 is older

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use0) begin
            lru_q[index] <= 1'b1;
        end else if (use1) begin
            lru_q[index] <= 1'b0;
        end
    end

    assign victim = lru_q[index];

    // controller touches one way per cycle
    a_single_use: assert property (@(posedge clk) disable iff (!rstn) !(use0 && use1));

endmodule

// ==== logic/icache_fsm_main.sv ====
`timescale 1ns/10ps

module icache_fsm_main (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            req_valid,
    input  logic                            req_opflag,
    input  icache_pkg::pipe_ctrl_t          ctrl,
    input  icache_pkg::fetch_req_t          buf_req,
    input  logic [icache_pkg::num_ways-1:0] hit,
    input  logic                            victim,
    input  logic                            mem_data_ok,
    output logic                            buf_we,
    output logic                            mem_req,
    output logic                            rdata_valid,
    output logic                            op_done,
    output logic                            stall,
    output logic                            choose_return,
    output logic                            choose_way,
    output logic                            use0,
    output logic                            use1,
    output logic [icache_pkg::num_ways-1:0] data_we,
    output logic [icache_pkg::num_ways-1:0] inval,
    output logic                            init_set
);

    icache_pkg::fsm_state_e  state;
    icache_pkg::fsm_state_e  next_state;
    icache_pkg::fsm_state_e  accept_state;
    icache_pkg::cacop_kind_e op_kind;
    logic                    miss;
    logic                    is_barrier;
    logic                    flush_pend;
    logic                    rstn_q;
    logic                    valid_raw;

    assign miss         = !(|hit) || buf_req.uncached;
    assign is_barrier   = buf_req.op.ibar.barrier;
    assign op_kind      = buf_req.op.cacop.kind;
    assign accept_state = req_opflag ? icache_pkg::operation :
                          req_valid  ? icache_pkg::lookup : icache_pkg::idle;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= icache_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    // flush seen while memory is busy, acted on at data_ok
    always_ff @(posedge clk) begin
        if (!rstn) begin
            flush_pend <= 1'b0;
        end else if (state == icache_pkg::miss_wait && !mem_data_ok) begin
            flush_pend <= flush_pend | ctrl.flush;
        end else begin
            flush_pend <= 1'b0;
        end
    end

    // no result in the first cycle out of reset
    always_ff @(posedge clk) begin
        rstn_q <= rstn;
    end
    assign rdata_valid = valid_raw & rstn_q;

    //////////////////////////////
    // next state and outputs
    //////////////////////////////
    always_comb begin
        next_state    = state;
        buf_we        = 1'b0;
        mem_req       = 1'b0;
        valid_raw     = 1'b0;
        op_done       = 1'b0;
        stall         = 1'b0;
        choose_return = 1'b0;
        choose_way    = hit[1];
        use0          = 1'b0;
        use1          = 1'b0;
        data_we       = '0;
        inval         = '0;
        init_set      = 1'b0;
        case (state)
            icache_pkg::idle: begin
                if (!ctrl.stall && !ctrl.flush) begin
                    buf_we     = 1'b1;
                    next_state = accept_state;
                end
            end
            icache_pkg::lookup: begin
                if (ctrl.flush) begin
                    next_state = icache_pkg::flush;  // result dropped
                end else if (!ctrl.stall) begin
                    if (miss) begin
                        mem_req    = 1'b1;
                        stall      = 1'b1;
                        inval      = buf_req.uncached ? hit : '0;  // uncached drops the line
                        next_state = icache_pkg::miss_wait;
                    end else begin
                        valid_raw  = 1'b1;
                        buf_we     = 1'b1;
                        use0       = hit[0];
                        use1       = hit[1];
                        next_state = accept_state;
                    end
                end
            end
            icache_pkg::miss_wait: begin
                mem_req = 1'b1;
                if (!mem_data_ok) begin
                    stall = 1'b1;
                end else begin
                    choose_return = 1'b1;
                    if (!buf_req.uncached) begin
                        data_we = victim ? 2'b10 : 2'b01;  // refill lru way
                        use0    = !victim;
                        use1    = victim;
                    end
                    if (flush_pend || ctrl.flush) begin
                        next_state = icache_pkg::flush;
                    end else begin
                        valid_raw = 1'b1;
                        if (!ctrl.stall) begin
                            buf_we     = 1'b1;
                            next_state = accept_state;
                        end else begin
                            next_state = icache_pkg::idle;
                        end
                    end
                end
            end
            icache_pkg::operation: begin
                if (ctrl.flush) begin
                    next_state = icache_pkg::flush;
                end else if (!ctrl.stall) begin
                    op_done    = 1'b1;
                    buf_we     = 1'b1;
                    next_state = accept_state;
                    if (!is_barrier) begin  // ibar only acks
                        case (op_kind)
                            icache_pkg::cacop_init:        init_set = 1'b1;
                            icache_pkg::cacop_index_inval: begin
                                inval = buf_req.addr.offset[0] ? 2'b10 : 2'b01;
                            end
                            icache_pkg::cacop_hit_inval:   inval = hit;
                            default: ;
                        endcase
                    end
                end
            end
            icache_pkg::flush: begin
                if (!ctrl.flush && !ctrl.stall) begin
                    buf_we     = 1'b1;
                    next_state = accept_state;
                end
            end
            default: next_state = icache_pkg::idle;
        endcase
    end

    // memory answers only a pending refill
    a_data_ok_in_wait: assert property (@(posedge clk) disable iff (!rstn)
        mem_data_ok |-> state == icache_pkg::miss_wait);

endmodule

// ==== logic/icache_top.sv ====
`timescale 1ns/10ps

module icache_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  icache_pkg::fetch_req_t   req,
    input  icache_pkg::pipe_ctrl_t   ctrl,
    output logic                     rdata_valid,
    output logic [31:0]              rdata,
    output logic                     stall,
    output logic                     op_done,
    output logic                     mem_req,
    output icache_pkg::icache_addr_t mem_addr,
    input  logic                     mem_data_ok,
    input  logic [31:0]              mem_rdata
);

    icache_pkg::fetch_req_t             buf_req;
    logic                               buf_we;
    logic [icache_pkg::index_width-1:0] rd_index;
    logic [icache_pkg::num_ways-1:0]    hit;
    logic [icache_pkg::num_ways-1:0]    data_we;
    logic [icache_pkg::num_ways-1:0]    inval;
    logic                               init_set;
    logic                               victim;
    logic                               use0;
    logic                               use1;
    logic                               choose_return;
    logic                               choose_way;
    logic [31:0]                        way0_word;
    logic [31:0]                        way1_word;

    // new index on accept, else keep re-reading the buffered one
    assign rd_index = buf_we ? req.addr.index : buf_req.addr.index;
    assign mem_addr = buf_req.addr;

    icache_req_buf icache_req_buf_i (
        .clk     (clk),
        .rstn    (rstn),
        .we      (buf_we),
        .req_in  (req),
        .req_out (buf_req)
    );

    icache_tagv_array icache_tagv_array_i (
        .clk      (clk),
        .rstn     (rstn),
        .rd_index (rd_index),
        .cmp_addr (buf_req.addr),
        .we       (data_we),      // tag written with the data
        .wr_addr  (buf_req.addr),
        .inval    (inval),
        .init_set (init_set),
        .hit      (hit)
    );

    icache_data_array icache_data_array_i (
        .clk      (clk),
        .rd_index (rd_index),
        .we       (data_we),
        .wr_index (buf_req.addr.index),
        .wdata    (mem_rdata),
        .rdata0   (way0_word),
        .rdata1   (way1_word)
    );

    icache_lru icache_lru_i (
        .clk    (clk),
        .rstn   (rstn),
        .index  (buf_req.addr.index),
        .use0   (use0),
        .use1   (use1),
        .victim (victim)
    );

    icache_fsm_main icache_fsm_main_i (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req.valid),
        .req_opflag    (req.opflag),
        .ctrl          (ctrl),
        .buf_req       (buf_req),
        .hit           (hit),
        .victim        (victim),
        .mem_data_ok   (mem_data_ok),
        .buf_we        (buf_we),
        .mem_req       (mem_req),
        .rdata_valid   (rdata_valid),
        .op_done       (op_done),
        .stall         (stall),
        .choose_return (choose_return),
        .choose_way    (choose_way),
        .use0          (use0),
        .use1          (use1),
        .data_we       (data_we),
        .inval         (inval),
        .init_set      (init_set)
    );

    //////////////////////////////
    // returned word
    //////////////////////////////
    always_comb begin
        if (choose_return) begin
            rdata = mem_rdata;  // refill or uncached word
        end else if (choose_way) begin
            rdata = way1_word;
        end else begin
            rdata = way0_word;
        end
    end

endmodule

// ==== verif/icache_tb.sv ====
`timescale 1ns/10ps

module icache_tb;

    localparam int test_cycles    = 400;  // rough upper bound of the whole sequence
    localparam int mem_wait_limit = 16;

    // op words, per the two decodes of the op word
    localparam logic [31:0] op_init        = 32'h0000_0000;
    localparam logic [31:0] op_index_inval = 32'h0000_0008;
    localparam logic [31:0] op_hit_inval   = 32'h0000_0010;
    localparam logic [31:0] op_ibar        = 32'h8000_0000;

    logic                     clk;
    logic                     rstn;
    icache_pkg::fetch_req_t   req;
    icache_pkg::pipe_ctrl_t   ctrl;
    logic                     rdata_valid;
    logic [31:0]              rdata;
    logic                     stall;
    logic                     op_done;
    logic                     mem_req;
    icache_pkg::icache_addr_t mem_addr;
    logic                     mem_data_ok;
    logic [31:0]              mem_rdata;
    logic [15:0]              lfsr_state = 16'd7;

    icache_top icache_top_i (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .ctrl        (ctrl),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .stall       (stall),
        .op_done     (op_done),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            abort_run($sformatf("Mismatch at %0t: %s, got %h, expected %h",
                                $time, what, got, expected));
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic int draw_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    function automatic logic [31:0] make_addr(input logic [25:0] tag, input logic [3:0] index,
                                              input logic [1:0] offset);
        return {tag, index, offset};
    endfunction

    // memory answers 1..4 cycles after the request, word = inverted address
    initial begin : memory_model
        int          delay;
        logic [31:0] addr_word;
        forever begin
            @(negedge clk);
            if (mem_req && !mem_data_ok) begin
                delay = draw_bits(2);
                repeat (delay + 1) @(posedge clk);
                #1;
                addr_word   = mem_addr;
                mem_data_ok = 1'b1;
                mem_rdata   = ~addr_word;
                @(posedge clk);
                #1;
                mem_data_ok = 1'b0;
            end
        end
    end

    // entered 1 ns after an edge with the cache idle
    task automatic fetch_word(input logic [31:0] addr, input logic uncached,
                              input logic expect_miss, input string what);
        logic miss_seen;
        int   waited;
        req          = '0;
        req.valid    = 1'b1;
        req.uncached = uncached;
        req.addr     = addr;
        @(posedge clk);
        #1;
        req = '0;
        @(negedge clk);  // lookup cycle
        miss_seen = mem_req;
        check_value(32'(miss_seen), 32'(expect_miss), {what, ": miss"});
        if (!miss_seen) begin
            check_value(32'(rdata_valid), 32'd1,
                        {what, ": hit data one cycle after accept"});
            check_value(32'(stall), 32'd0, {what, ": no stall on hit"});
        end else begin
            check_value(32'(stall), 32'd1, {what, ": stall on miss"});
            check_value(32'(rdata_valid), 32'd0, {what, ": no data in miss lookup"});
            check_value(mem_addr, addr, {what, ": memory address"});
            waited = 0;
            while (!rdata_valid) begin
                waited++;
                if (waited > mem_wait_limit) begin
                    abort_run({what, ": refill word never came back"});
                end
                @(negedge clk);
            end
        end
        check_value(rdata, ~addr, {what, ": returned word"});
        @(posedge clk);
        #1;
    endtask

    task automatic run_cache_op(input logic [31:0] addr, input logic [31:0] op_word,
                                input string what);
        req        = '0;
        req.valid  = 1'b1;
        req.opflag = 1'b1;
        req.addr   = addr;
        req.op     = op_word;
        @(posedge clk);
        #1;
        req = '0;
        @(negedge clk);
        check_value(32'(op_done), 32'd1, {what, ": op_done"});
        check_value(32'(rdata_valid), 32'd0, {what, ": no data on op"});
        check_value(32'(mem_req), 32'd0, {what, ": no memory access on op"});
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic miss_then_hit();
        logic [31:0] a;
        a = make_addr(26'h0ABCDE, 4'd3, 2'd0);
        fetch_word(a, 1'b0, 1'b1, "first fetch");
        fetch_word(a, 1'b0, 1'b0, "repeat fetch");
    endtask

    task automatic lru_replacement();
        logic [31:0] b0;
        logic [31:0] b1;
        logic [31:0] b2;
        b0 = make_addr(26'h0000111, 4'd5, 2'd0);
        b1 = make_addr(26'h0000222, 4'd5, 2'd0);
        b2 = make_addr(26'h0000333, 4'd5, 2'd0);
        fetch_word(b0, 1'b0, 1'b1, "lru fill way 0");
        fetch_word(b1, 1'b0, 1'b1, "lru fill way 1");
        fetch_word(b0, 1'b0, 1'b0, "lru touch b0");  // b1 now oldest
        fetch_word(b2, 1'b0, 1'b1, "lru replace");
        fetch_word(b0, 1'b0, 1'b0, "lru b0 kept");
        fetch_word(b2, 1'b0, 1'b0, "lru b2 resident");
        fetch_word(b1, 1'b0, 1'b1, "lru evicted refetch");
    endtask

    task automatic uncached_bypass();
        logic [31:0] c;
        logic [31:0] d;
        c = make_addr(26'h00A5C3, 4'd7, 2'd0);
        d = make_addr(26'h0001234, 4'd7, 2'd0);
        fetch_word(c, 1'b0, 1'b1, "uc fill");
        fetch_word(c, 1'b0, 1'b0, "uc resident");
        fetch_word(c, 1'b1, 1'b1, "uc resident bypass");
        fetch_word(c, 1'b0, 1'b1, "uc line dropped");
        fetch_word(c, 1'b0, 1'b0, "uc refilled");
        fetch_word(d, 1'b1, 1'b1, "uc cold bypass");
        fetch_word(d, 1'b0, 1'b1, "uc not allocated");
    endtask

    task automatic cache_ops();
        logic [31:0] e0;
        logic [31:0] e1;
        e0 = make_addr(26'h01000AA, 4'd9, 2'd0);
        e1 = make_addr(26'h02000BB, 4'd9, 2'd0);
        fetch_word(e0, 1'b0, 1'b1, "ops fill way 0");
        fetch_word(e1, 1'b0, 1'b1, "ops fill way 1");
        // index init, way from addr bit 0
        run_cache_op(make_addr(26'h0, 4'd9, 2'd1), op_init, "index init way 1");
        fetch_word(e0, 1'b0, 1'b0, "after init, way 0 kept");
        fetch_word(e1, 1'b0, 1'b1, "after init, way 1 gone");
        run_cache_op(make_addr(26'h0, 4'd9, 2'd0), op_index_inval, "index inval way 0");
        fetch_word(e1, 1'b0, 1'b0, "after index inval, way 1 kept");
        fetch_word(e0, 1'b0, 1'b1, "after index inval, way 0 gone");
        run_cache_op(e1, op_hit_inval, "hit inval");
        fetch_word(e0, 1'b0, 1'b0, "after hit inval, other line kept");
        fetch_word(e1, 1'b0, 1'b1, "after hit inval, line gone");
        run_cache_op(e0, op_ibar, "ibar");
        fetch_word(e0, 1'b0, 1'b0, "after ibar, e0");
        fetch_word(e1, 1'b0, 1'b0, "after ibar, e1");
    endtask

    task automatic flush_and_stall();
        logic [31:0] f;
        logic [31:0] g;
        f = make_addr(26'h000F00F, 4'd11, 2'd0);
        g = make_addr(26'h0033CC0, 4'd12, 2'd0);
        fetch_word(f, 1'b0, 1'b1, "flush setup");
        fetch_word(f, 1'b0, 1'b0, "flush setup hit");
        // flush lands on the hit lookup
        req       = '0;
        req.valid = 1'b1;
        req.addr  = f;
        @(posedge clk);
        #1;
        req        = '0;
        ctrl.flush = 1'b1;
        @(negedge clk);
        check_value(32'(rdata_valid), 32'd0, "flushed lookup result");
        check_value(32'(mem_req), 32'd0, "flushed lookup memory");
        @(posedge clk);
        #1;
        ctrl.flush = 1'b0;
        @(negedge clk);
        check_value(32'(rdata_valid), 32'd0, "flush state result");
        @(posedge clk);
        #1;
        fetch_word(f, 1'b0, 1'b0, "hit after flush");
        // stall while idle, request pending
        ctrl.stall = 1'b1;
        req        = '0;
        req.valid  = 1'b1;
        req.addr   = g;
        repeat (3) begin
            @(negedge clk);
            check_value(32'(mem_req), 32'd0, "stalled idle memory");
            check_value(32'(rdata_valid), 32'd0, "stalled idle result");
            @(posedge clk);
            #1;
        end
        ctrl.stall = 1'b0;
        fetch_word(g, 1'b0, 1'b1, "released after stall");
        // stall holding a hit lookup
        req.valid = 1'b1;
        req.addr  = g;
        @(posedge clk);
        #1;
        req        = '0;
        ctrl.stall = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_value(32'(rdata_valid), 32'd0, "stalled lookup result");
            check_value(32'(mem_req), 32'd0, "stalled lookup memory");
            @(posedge clk);
            #1;
        end
        ctrl.stall = 1'b0;
        @(negedge clk);
        check_value(32'(rdata_valid), 32'd1, "lookup result after release");
        check_value(rdata, ~g, "lookup word after release");
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        rstn        = 1'b0;
        req         = '0;
        ctrl        = '0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;
        miss_then_hit();
        lru_replacement();
        uncached_bypass();
        cache_ops();
        flush_and_stall();
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        repeat (test_cycles * 10) @(posedge clk);
        abort_run($sformatf("timeout: tests still running after %0d cycles",
                            test_cycles * 10));
    end

endmodule

// ==== icache_sub.f ====
logic/icache_pkg.sv
logic/icache_req_buf.sv
logic/icache_tagv_array.sv
logic/icache_data_array.sv
logic/icache_lru.sv
logic/icache_fsm_main.sv
logic/icache_top.sv
verif/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f icache_sub.f \
    --top-module icache_tb \
    --Mdir obj_dir -o icache_sim

# the simulator exits non-zero on $fatal, so keep going and judge by the log
./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
